// ==== hw/adc_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "slow_adc_config.svh"

module adc_sequencer (
  input  wire                     clk,
  input  wire                     rst,
  output slow_adc_pkg::byte_op_e  byte_op_o,
  output logic [7:0]              tx_byte_o,
  output logic                    byte_req_o,
  input  wire                     byte_ack_i,
  input  wire                     nack_i,
  output logic                    data_strobe_o,
  output logic [2:0]              byte_index_o,
  output logic                    missed_ack_o
);

  localparam logic [2:0] LAST_BYTE = 3'(`SLOW_ADC_CHANNELS * 2 - 1);

  slow_adc_pkg::seq_state_e state;
  logic [2:0]               byte_cnt;
  logic                     byte_done;

  assign byte_done = byte_req_o && byte_ack_i;

  // op and data follow the state, which only moves once the request drops.
  always_comb begin
    byte_op_o = slow_adc_pkg::OP_STOP;
    tx_byte_o = 8'h00;
    case (state)
      slow_adc_pkg::S_W_START,
      slow_adc_pkg::S_R_START: begin
        byte_op_o = slow_adc_pkg::OP_START;
      end
      slow_adc_pkg::S_W_ADDR: begin
        byte_op_o = slow_adc_pkg::OP_WRITE;
        tx_byte_o = {`SLOW_ADC_ADDR, 1'b0};
      end
      slow_adc_pkg::S_W_CFG: begin
        byte_op_o = slow_adc_pkg::OP_WRITE;
        tx_byte_o = `SLOW_ADC_CFG_BYTE;
      end
      slow_adc_pkg::S_R_ADDR: begin
        byte_op_o = slow_adc_pkg::OP_WRITE;
        tx_byte_o = {`SLOW_ADC_ADDR, 1'b1};
      end
      slow_adc_pkg::S_R_DATA: begin
        // the last byte of the burst is nacked.
        byte_op_o = (byte_cnt == LAST_BYTE) ? slow_adc_pkg::OP_READ_NACK
                                            : slow_adc_pkg::OP_READ_ACK;
      end
      default: begin
        byte_op_o = slow_adc_pkg::OP_STOP;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // sweep control.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= slow_adc_pkg::S_IDLE;
      byte_req_o    <= 1'b0;
      byte_cnt      <= 3'd0;
      data_strobe_o <= 1'b0;
      byte_index_o  <= 3'd0;
      missed_ack_o  <= 1'b0;
    end else begin
      data_strobe_o <= 1'b0;
      missed_ack_o  <= 1'b0;

      if (byte_done) begin
        byte_req_o <= 1'b0;
      end else if (!byte_req_o && !byte_ack_i && (state != slow_adc_pkg::S_IDLE)) begin
        byte_req_o <= 1'b1;
      end

      if (state == slow_adc_pkg::S_IDLE) begin
        state <= slow_adc_pkg::S_W_START;
      end else if (byte_done) begin
        case (state)
          slow_adc_pkg::S_W_START: state <= slow_adc_pkg::S_W_ADDR;
          slow_adc_pkg::S_W_STOP:  state <= slow_adc_pkg::S_R_START;
          slow_adc_pkg::S_R_START: state <= slow_adc_pkg::S_R_ADDR;
          slow_adc_pkg::S_W_ADDR,
          slow_adc_pkg::S_W_CFG,
          slow_adc_pkg::S_R_ADDR: begin
            if (nack_i) begin
              missed_ack_o <= 1'b1;
              state        <= slow_adc_pkg::S_ABORT;
            end else if (state == slow_adc_pkg::S_W_ADDR) begin
              state <= slow_adc_pkg::S_W_CFG;
            end else if (state == slow_adc_pkg::S_W_CFG) begin
              state <= slow_adc_pkg::S_W_STOP;
            end else begin
              byte_cnt <= 3'd0;
              state    <= slow_adc_pkg::S_R_DATA;
            end
          end
          slow_adc_pkg::S_R_DATA: begin
            data_strobe_o <= 1'b1;
            byte_index_o  <= byte_cnt;
            if (byte_cnt == LAST_BYTE) begin
              state <= slow_adc_pkg::S_R_STOP;
            end else begin
              byte_cnt <= byte_cnt + 3'd1;
            end
          end
          default: begin
            // stop of a finished or aborted sweep.
            state <= slow_adc_pkg::S_W_START;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/i2c_bit_phy.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "slow_adc_config.svh"

module i2c_bit_phy (
  input  wire                    clk,
  input  wire                    rst,
  input  wire slow_adc_pkg::bit_op_e bit_op_i,
  input  wire                    bit_tx_i,
  input  wire                    bit_req_i,
  output logic                   bit_ack_o,
  output logic                   bit_rx_o,
  input  wire                    scl_i,
  input  wire                    sda_i,
  output logic                   scl_t_o,
  output logic                   sda_t_o
);

  localparam logic [15:0] QUARTER_LAST = `SLOW_ADC_PRESCALE - 16'd1;

  slow_adc_pkg::bit_op_e op_q;
  logic                  tx_q;
  logic                  busy;
  logic [1:0]            quarter;
  logic [15:0]           presc_cnt;
  logic                  start_bit;
  logic                  stretched;
  logic                  quarter_end;

  // line levels {scl, sda} for one quarter of a bit op.
  // every op but STOP leaves SCL low at the end.
  function automatic logic [1:0] line_drive(input slow_adc_pkg::bit_op_e op,
                                            input logic tx,
                                            input logic [1:0] q);
    logic scl;
    logic sda;
    scl = (q == 2'd1) || (q == 2'd2);
    sda = 1'b1;
    case (op)
      slow_adc_pkg::BIT_START: begin
        // sda falls in q2 while scl is high.
        sda = (q < 2'd2);
      end
      slow_adc_pkg::BIT_STOP: begin
        // sda rises in q2 while scl is high.
        scl = (q != 2'd0);
        sda = q[1];
      end
      slow_adc_pkg::BIT_WRITE: begin
        sda = tx;
      end
      default: begin
        sda = 1'b1;
      end
    endcase
    return {scl, sda};
  endfunction

  assign start_bit = !busy && !bit_ack_o && bit_req_i;

  // a released SCL held low by the slave freezes the quarter.
  assign stretched = scl_t_o && !scl_i;

  assign quarter_end = busy && !stretched && (presc_cnt == 16'd0);

  ////////////////////////////////////////////////////////////
  // quarter sequencing and line drive.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      bit_ack_o <= 1'b0;
      quarter   <= 2'd0;
      presc_cnt <= 16'd0;
      scl_t_o   <= 1'b1;
      sda_t_o   <= 1'b1;
    end else begin
      if (start_bit) begin
        busy                 <= 1'b1;
        quarter              <= 2'd0;
        presc_cnt            <= QUARTER_LAST;
        {scl_t_o, sda_t_o}   <= line_drive(bit_op_i, bit_tx_i, 2'd0);
      end else if (busy) begin
        if (quarter_end) begin
          if (quarter == 2'd3) begin
            busy      <= 1'b0;
            bit_ack_o <= 1'b1;
          end else begin
            quarter            <= quarter + 2'd1;
            presc_cnt          <= QUARTER_LAST;
            {scl_t_o, sda_t_o} <= line_drive(op_q, tx_q, quarter + 2'd1);
          end
        end else if (!stretched) begin
          presc_cnt <= presc_cnt - 16'd1;
        end
      end else if (bit_ack_o && !bit_req_i) begin
        bit_ack_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_bit) begin
      op_q <= bit_op_i;
      tx_q <= bit_tx_i;
    end
    // sample at the end of the third quarter, scl high.
    if (quarter_end && (quarter == 2'd2) && (op_q == slow_adc_pkg::BIT_READ)) begin
      bit_rx_o <= sda_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/i2c_byte_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_shifter (
  input  wire                     clk,
  input  wire                     rst,
  input  wire slow_adc_pkg::byte_op_e byte_op_i,
  input  wire [7:0]               tx_byte_i,
  input  wire                     byte_req_i,
  output logic                    byte_ack_o,
  output logic [7:0]              rx_byte_o,
  output logic                    nack_o,
  output slow_adc_pkg::bit_op_e   bit_op_o,
  output logic                    bit_tx_o,
  output logic                    bit_req_o,
  input  wire                     bit_ack_i,
  input  wire                     bit_rx_i
);

  typedef enum logic [1:0] {
    SH_IDLE,
    SH_REQ,
    SH_REL,
    SH_DONE
  } sh_state_e;

  sh_state_e              state;
  slow_adc_pkg::byte_op_e op_q;
  logic [7:0]             shreg;
  logic [3:0]             bit_cnt;
  logic                   last_bit;
  logic                   next_bit;

  // bit 8 is the ack slot, read for writes and written for reads.
  function automatic slow_adc_pkg::bit_op_e pick_op(input slow_adc_pkg::byte_op_e op,
                                                    input logic [3:0] idx);
    case (op)
      slow_adc_pkg::OP_START: return slow_adc_pkg::BIT_START;
      slow_adc_pkg::OP_STOP:  return slow_adc_pkg::BIT_STOP;
      slow_adc_pkg::OP_WRITE: begin
        return (idx == 4'd8) ? slow_adc_pkg::BIT_READ : slow_adc_pkg::BIT_WRITE;
      end
      default: begin
        return (idx == 4'd8) ? slow_adc_pkg::BIT_WRITE : slow_adc_pkg::BIT_READ;
      end
    endcase
  endfunction

  function automatic logic pick_tx(input slow_adc_pkg::byte_op_e op,
                                   input logic [3:0] idx,
                                   input logic msb);
    if (op == slow_adc_pkg::OP_WRITE) begin
      return msb;
    end
    if (idx == 4'd8) begin
      return (op == slow_adc_pkg::OP_READ_NACK);
    end
    return 1'b1;
  endfunction

  assign last_bit = (op_q == slow_adc_pkg::OP_START) ||
                    (op_q == slow_adc_pkg::OP_STOP) ||
                    (bit_cnt == 4'd8);

  assign next_bit = (state == SH_REL) && !bit_ack_i && !last_bit;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= SH_IDLE;
      byte_ack_o <= 1'b0;
      bit_req_o  <= 1'b0;
      nack_o     <= 1'b0;
      bit_cnt    <= 4'd0;
    end else begin
      case (state)
        SH_IDLE: begin
          if (byte_req_i) begin
            bit_cnt   <= 4'd0;
            nack_o    <= 1'b0;
            bit_req_o <= 1'b1;
            state     <= SH_REQ;
          end
        end
        SH_REQ: begin
          if (bit_ack_i) begin
            bit_req_o <= 1'b0;
            if ((op_q == slow_adc_pkg::OP_WRITE) && (bit_cnt == 4'd8)) begin
              nack_o <= bit_rx_i;
            end
            state <= SH_REL;
          end
        end
        SH_REL: begin
          if (!bit_ack_i) begin
            if (last_bit) begin
              byte_ack_o <= 1'b1;
              state      <= SH_DONE;
            end else begin
              bit_cnt   <= bit_cnt + 4'd1;
              bit_req_o <= 1'b1;
              state     <= SH_REQ;
            end
          end
        end
        default: begin
          if (!byte_req_i) begin
            byte_ack_o <= 1'b0;
            state      <= SH_IDLE;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // data path, msb first in both directions.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if ((state == SH_IDLE) && byte_req_i) begin
      op_q     <= byte_op_i;
      shreg    <= tx_byte_i;
      bit_op_o <= pick_op(byte_op_i, 4'd0);
      bit_tx_o <= pick_tx(byte_op_i, 4'd0, tx_byte_i[7]);
    end
    if ((state == SH_REQ) && bit_ack_i && (bit_cnt < 4'd8)) begin
      shreg <= {shreg[6:0], bit_rx_i};
    end
    if (next_bit) begin
      bit_op_o <= pick_op(op_q, bit_cnt + 4'd1);
      bit_tx_o <= pick_tx(op_q, bit_cnt + 4'd1, shreg[7]);
    end
    if ((state == SH_REL) && !bit_ack_i && last_bit) begin
      rx_byte_o <= shreg;
    end
  end

endmodule

`default_nettype wire

// ==== hw/sample_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "slow_adc_config.svh"

module sample_assembler (
  input  wire         clk,
  input  wire         rst,
  input  wire         data_strobe_i,
  input  wire  [2:0]  byte_index_i,
  input  wire  [7:0]  rx_byte_i,
  output logic [11:0] ain0_o,
  output logic [11:0] ain1_o,
  output logic [11:0] ain2_o,
  output logic [11:0] ain3_o,
  output logic        sample_valid_o
);

  localparam logic [2:0] LAST_BYTE = 3'(`SLOW_ADC_CHANNELS * 2 - 1);

  logic [3:0] msb_nibble;

  // even bytes carry the top four bits in the low nibble.
  always_ff @(posedge clk) begin
    if (data_strobe_i && !byte_index_i[0]) begin
      msb_nibble <= rx_byte_i[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ain0_o         <= 12'd0;
      ain1_o         <= 12'd0;
      ain2_o         <= 12'd0;
      ain3_o         <= 12'd0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= data_strobe_i && (byte_index_i == LAST_BYTE);
      if (data_strobe_i && byte_index_i[0]) begin
        case (byte_index_i[2:1])
          2'd0:    ain0_o <= {msb_nibble, rx_byte_i};
          2'd1:    ain1_o <= {msb_nibble, rx_byte_i};
          2'd2:    ain2_o <= {msb_nibble, rx_byte_i};
          default: ain3_o <= {msb_nibble, rx_byte_i};
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/slow_adc_pkg.sv ====
`default_nettype none

package slow_adc_pkg;

  // byte level commands, sequencer to shifter.
  typedef enum logic [2:0] {
    OP_START,
    OP_STOP,
    OP_WRITE,
    OP_READ_ACK,
    OP_READ_NACK
  } byte_op_e;

  // bit level commands, shifter to phy.
  typedef enum logic [1:0] {
    BIT_START,
    BIT_STOP,
    BIT_WRITE,
    BIT_READ
  } bit_op_e;

  typedef enum logic [3:0] {
    S_IDLE,
    S_W_START,
    S_W_ADDR,
    S_W_CFG,
    S_W_STOP,
    S_R_START,
    S_R_ADDR,
    S_R_DATA,
    S_R_STOP,
    S_ABORT
  } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/slow_adc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module slow_adc_top (
  input  wire         clk,
  input  wire         rst,
  input  wire         scl_i,
  input  wire         sda_i,
  output logic        scl_t_o,
  output logic        sda_t_o,
  output logic [11:0] ain0_o,
  output logic [11:0] ain1_o,
  output logic [11:0] ain2_o,
  output logic [11:0] ain3_o,
  output logic        sample_valid_o,
  output logic        missed_ack_o
);

  slow_adc_pkg::byte_op_e byte_op;
  logic [7:0]             tx_byte;
  logic                   byte_req;
  logic                   byte_ack;
  logic [7:0]             rx_byte;
  logic                   nack;

  slow_adc_pkg::bit_op_e  bit_op;
  logic                   bit_tx;
  logic                   bit_req;
  logic                   bit_ack;
  logic                   bit_rx;

  logic                   data_strobe;
  logic [2:0]             byte_index;

  adc_sequencer u_sequencer (
    .clk           (clk),
    .rst           (rst),
    .byte_op_o     (byte_op),
    .tx_byte_o     (tx_byte),
    .byte_req_o    (byte_req),
    .byte_ack_i    (byte_ack),
    .nack_i        (nack),
    .data_strobe_o (data_strobe),
    .byte_index_o  (byte_index),
    .missed_ack_o  (missed_ack_o)
  );

  i2c_byte_shifter u_shifter (
    .clk        (clk),
    .rst        (rst),
    .byte_op_i  (byte_op),
    .tx_byte_i  (tx_byte),
    .byte_req_i (byte_req),
    .byte_ack_o (byte_ack),
    .rx_byte_o  (rx_byte),
    .nack_o     (nack),
    .bit_op_o   (bit_op),
    .bit_tx_o   (bit_tx),
    .bit_req_o  (bit_req),
    .bit_ack_i  (bit_ack),
    .bit_rx_i   (bit_rx)
  );

  i2c_bit_phy u_phy (
    .clk       (clk),
    .rst       (rst),
    .bit_op_i  (bit_op),
    .bit_tx_i  (bit_tx),
    .bit_req_i (bit_req),
    .bit_ack_o (bit_ack),
    .bit_rx_o  (bit_rx),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .scl_t_o   (scl_t_o),
    .sda_t_o   (sda_t_o)
  );

  sample_assembler u_assembler (
    .clk            (clk),
    .rst            (rst),
    .data_strobe_i  (data_strobe),
    .byte_index_i   (byte_index),
    .rx_byte_i      (rx_byte),
    .ain0_o         (ain0_o),
    .ain1_o         (ain1_o),
    .ain2_o         (ain2_o),
    .ain3_o         (ain3_o),
    .sample_valid_o (sample_valid_o)
  );

endmodule

`default_nettype wire

// ==== include/slow_adc_config.svh ====
`ifndef SLOW_ADC_CONFIG_SVH
`define SLOW_ADC_CONFIG_SVH

////////////////////////////////////////////////////////////
// slave and sweep setup.
////////////////////////////////////////////////////////////

// 7-bit I2C address of the ADC.
`define SLOW_ADC_ADDR 7'h34

// configuration byte written before every read burst.
`define SLOW_ADC_CFG_BYTE 8'h07

// clock cycles per quarter of an SCL bit.
`define SLOW_ADC_PRESCALE 16'd4

// two bytes per channel on the read burst.
`define SLOW_ADC_CHANNELS 4

`endif

// ==== project.f ====
+incdir+include
hw/slow_adc_pkg.sv
hw/i2c_bit_phy.sv
hw/i2c_byte_shifter.sv
hw/adc_sequencer.sv
hw/sample_assembler.sv
hw/slow_adc_top.sv
testbench/adc_i2c_model.sv
testbench/tb_slow_adc.sv

// ==== testbench/adc_i2c_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "slow_adc_config.svh"

module adc_i2c_model (
  input  wire         clk,
  input  wire         rst,
  input  wire         scl_i,
  input  wire         sda_i,
  output logic        scl_t_o,
  output logic        sda_t_o,
  input  wire         load_i,
  input  wire  [63:0] rd_bytes_i,
  input  wire  [7:0]  nack_count_i,
  input  wire  [7:0]  stretch_i,
  output logic [15:0] proto_err_o
);

  localparam int M_IDLE  = 0;
  localparam int M_ADDR  = 1;
  localparam int M_WDATA = 2;
  localparam int M_RDATA = 3;

  logic [7:0] rd_q [0:7];
  logic [7:0] nack_left;
  logic [7:0] stretch_q;
  logic [7:0] stretch_cnt;
  logic       prev_scl;
  logic       prev_sda;
  int         mode;
  int         phase;
  logic [3:0] bit_cnt;
  logic [7:0] shreg;
  logic       ack_q;
  logic       addr_rd;
  logic       m_nack;
  int         rd_idx;

  task automatic proto_error(input string msg);
    $display("model error at %0t: %s", $time, msg);
    proto_err_o <= proto_err_o + 16'd1;
  endtask

  // phase: 0 write addr, 1 config, 2 stop, 3 read addr, 4 stop after burst,
  // 5 stop after injected nack, 6 reading.
  always @(posedge clk) begin : step
    logic ack_ok;
    ack_ok = 1'b1;
    if (load_i) begin
      for (int k = 0; k < 8; k++) begin
        rd_q[k] <= rd_bytes_i[8*k +: 8];
      end
      nack_left <= nack_count_i;
      stretch_q <= stretch_i;
    end
    if (rst) begin
      prev_scl    <= 1'b1;
      prev_sda    <= 1'b1;
      scl_t_o     <= 1'b1;
      sda_t_o     <= 1'b1;
      mode        <= M_IDLE;
      phase       <= 0;
      bit_cnt     <= 4'd0;
      stretch_cnt <= 8'd0;
      proto_err_o <= 16'd0;
    end else begin
      prev_scl <= scl_i;
      prev_sda <= sda_i;
      if (stretch_cnt != 8'd0) begin
        stretch_cnt <= stretch_cnt - 8'd1;
        if (stretch_cnt == 8'd1) begin
          scl_t_o <= 1'b1;
        end
      end
      if (prev_scl && scl_i && prev_sda && !sda_i) begin
        mode    <= M_ADDR;
        bit_cnt <= 4'd0;
        sda_t_o <= 1'b1;
        if (phase != 0 && phase != 3) begin
          proto_error("START arrived in the middle of a transfer");
        end
      end else if (prev_scl && scl_i && !prev_sda && sda_i) begin
        mode    <= M_IDLE;
        sda_t_o <= 1'b1;
        case (phase)
          2:       phase <= 3;
          4, 5:    phase <= 0;
          default: proto_error("STOP arrived at an unexpected point");
        endcase
      end else if (!prev_scl && scl_i && mode != M_IDLE) begin
        bit_cnt <= bit_cnt + 4'd1;
        if (bit_cnt < 4'd8) begin
          shreg <= {shreg[6:0], sda_i};
        end
        if (mode == M_RDATA && bit_cnt == 4'd8) begin
          m_nack <= sda_i;
        end
      end else if (prev_scl && !scl_i && mode != M_IDLE) begin
        if (stretch_q != 8'd0) begin
          scl_t_o     <= 1'b0;
          stretch_cnt <= stretch_q;
        end
        if (mode == M_RDATA) begin
          if (bit_cnt < 4'd8) begin
            sda_t_o <= rd_q[rd_idx][7 - bit_cnt];
          end else if (bit_cnt == 4'd8) begin
            sda_t_o <= 1'b1;
          end else if (m_nack) begin
            if (rd_idx != 7) begin
              proto_error("read burst ended before eight bytes");
            end
            phase   <= 4;
            mode    <= M_IDLE;
            sda_t_o <= 1'b1;
          end else if (rd_idx == 7) begin
            proto_error("master acked the eighth byte and asked for more");
            mode    <= M_IDLE;
            sda_t_o <= 1'b1;
          end else begin
            rd_idx  <= rd_idx + 1;
            bit_cnt <= 4'd0;
            sda_t_o <= rd_q[rd_idx + 1][7];
          end
        end else if (bit_cnt == 4'd8) begin
          // decide the ack for the byte just received.
          if (mode == M_ADDR && phase == 0) begin
            if (shreg != {`SLOW_ADC_ADDR, 1'b0}) begin
              proto_error("write address byte was wrong");
            end
            if (nack_left != 8'd0) begin
              nack_left <= nack_left - 8'd1;
              ack_ok = 1'b0;
              phase <= 5;
            end else begin
              phase <= 1;
            end
          end else if (mode == M_ADDR && phase == 3) begin
            if (shreg != {`SLOW_ADC_ADDR, 1'b1}) begin
              proto_error("read address byte was wrong");
            end
            phase <= 6;
          end else if (mode == M_WDATA && phase == 1) begin
            if (shreg != `SLOW_ADC_CFG_BYTE) begin
              proto_error("config byte was wrong");
            end
            phase <= 2;
          end else begin
            proto_error("a byte was written at an unexpected point");
            ack_ok = 1'b0;
          end
          sda_t_o <= !ack_ok;
          ack_q   <= ack_ok;
          addr_rd <= shreg[0];
        end else if (bit_cnt == 4'd9) begin
          sda_t_o <= 1'b1;
          bit_cnt <= 4'd0;
          if (!ack_q) begin
            mode <= M_IDLE;
          end else if (mode == M_ADDR && addr_rd) begin
            mode    <= M_RDATA;
            rd_idx  <= 0;
            sda_t_o <= rd_q[0][7];
          end else if (mode == M_ADDR) begin
            mode <= M_WDATA;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_slow_adc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "slow_adc_config.svh"

module tb_slow_adc;

  localparam int ROWS        = 6;
  localparam int MAX_STRETCH = 20;
  localparam int SWEEP_BITS  = 120;
  localparam int RETRY_BITS  = 20;

  logic        clk;
  logic        rst;
  wire         scl_line;
  wire         sda_line;
  logic        dut_scl_t;
  logic        dut_sda_t;
  logic        mdl_scl_t;
  logic        mdl_sda_t;
  logic [11:0] ain0;
  logic [11:0] ain1;
  logic [11:0] ain2;
  logic [11:0] ain3;
  logic        sample_valid;
  logic        missed_ack;
  logic        load;
  logic [63:0] rd_bytes;
  logic [7:0]  nack_count;
  logic [7:0]  stretch;
  logic [15:0] proto_err;

  logic [11:0] tab_val  [0:ROWS-1][0:3];
  logic [3:0]  tab_junk [0:ROWS-1][0:3];
  int          tab_nacks   [0:ROWS-1];
  int          tab_stretch [0:ROWS-1];

  int   fail_cnt;
  int   tests_ok;
  int   tests_bad;
  int   cycles;
  int   limit;
  int   miss_total;
  logic valid_prev;

  // open-drain bus, pulled up unless someone pulls low.
  assign scl_line = dut_scl_t & mdl_scl_t;
  assign sda_line = dut_sda_t & mdl_sda_t;

  slow_adc_top uut (
    .clk            (clk),
    .rst            (rst),
    .scl_i          (scl_line),
    .sda_i          (sda_line),
    .scl_t_o        (dut_scl_t),
    .sda_t_o        (dut_sda_t),
    .ain0_o         (ain0),
    .ain1_o         (ain1),
    .ain2_o         (ain2),
    .ain3_o         (ain3),
    .sample_valid_o (sample_valid),
    .missed_ack_o   (missed_ack)
  );

  adc_i2c_model model (
    .clk          (clk),
    .rst          (rst),
    .scl_i        (scl_line),
    .sda_i        (sda_line),
    .scl_t_o      (mdl_scl_t),
    .sda_t_o      (mdl_sda_t),
    .load_i       (load),
    .rd_bytes_i   (rd_bytes),
    .nack_count_i (nack_count),
    .stretch_i    (stretch),
    .proto_err_o  (proto_err)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // missed ack pulses and valid pulse width.
  always @(negedge clk) begin
    if (!rst) begin
      if (missed_ack) begin
        miss_total = miss_total + 1;
      end
      if (sample_valid) begin
        assert (!valid_prev) else begin
          $display("Fail t=%0t sample_valid_o expected 0 got 1", $time);
          fail_cnt = fail_cnt + 1;
        end
      end
    end
    valid_prev = sample_valid;
  end

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    assert (act === exp) else begin
      $display("Fail t=%0t %s expected %h got %h", $time, name, exp, act);
      fail_cnt = fail_cnt + 1;
    end
  endtask

  task automatic report_test(input string name, input int errors);
    if (errors == 0) begin
      tests_ok = tests_ok + 1;
      $display("%s: pass", name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("%s: fail, %0d errors", name, errors);
    end
  endtask

  task automatic load_row(input int r);
    for (int c = 0; c < `SLOW_ADC_CHANNELS; c++) begin
      rd_bytes[16*c +: 8]     = {tab_junk[r][c], tab_val[r][c][11:8]};
      rd_bytes[16*c + 8 +: 8] = tab_val[r][c][7:0];
    end
    nack_count = 8'(tab_nacks[r]);
    stretch    = 8'(tab_stretch[r]);
    load       = 1'b1;
    @(posedge clk);
    #1 load = 1'b0;
  endtask

  task automatic fill_table;
    int seed;
    int nack_sum;
    seed = $urandom(5);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < 4; c++) begin
        tab_val[r][c]  = 12'($urandom);
        tab_junk[r][c] = 4'($urandom);
      end
    end
    tab_val[0][0] = 12'h123;
    tab_val[0][1] = 12'h456;
    tab_val[0][2] = 12'h789;
    tab_val[0][3] = 12'habc;
    for (int c = 0; c < 4; c++) begin
      tab_junk[0][c] = 4'h0;
    end
    tab_val[1][0] = 12'hfff;
    tab_val[1][1] = 12'h000;
    tab_val[1][2] = 12'h800;
    tab_val[1][3] = 12'h001;
    tab_junk[1][0] = 4'hf;
    tab_junk[1][1] = 4'ha;
    tab_junk[1][2] = 4'h5;
    tab_junk[1][3] = 4'h0;
    tab_nacks   = '{0, 0, 2, 0, 1, 0};
    tab_stretch = '{0, 0, 0, 20, 12, 0};
    nack_sum = 0;
    for (int r = 0; r < ROWS; r++) begin
      nack_sum = nack_sum + tab_nacks[r];
    end
    limit = 2 * (ROWS * SWEEP_BITS + nack_sum * RETRY_BITS)
              * (4 * `SLOW_ADC_PRESCALE + MAX_STRETCH) + 20;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence.
  ////////////////////////////////////////////////////////////

  initial begin
    int miss_base;
    int err_base;
    int proto_base;
    clk        = 1'b0;
    rst        = 1'b1;
    load       = 1'b0;
    rd_bytes   = 64'd0;
    nack_count = 8'd0;
    stretch    = 8'd0;
    fail_cnt   = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    cycles     = 0;
    miss_total = 0;
    valid_prev = 1'b0;
    fill_table();
    load_row(0);
    @(posedge clk);
    #1 rst = 1'b0;

    err_base = fail_cnt;
    check_value("scl_t_o", 16'd1, 16'(dut_scl_t));
    check_value("sda_t_o", 16'd1, 16'(dut_sda_t));
    check_value("sample_valid_o", 16'd0, 16'(sample_valid));
    check_value("missed_ack_o", 16'd0, 16'(missed_ack));
    check_value("ain0_o", 16'd0, 16'(ain0));
    check_value("ain1_o", 16'd0, 16'(ain1));
    check_value("ain2_o", 16'd0, 16'(ain2));
    check_value("ain3_o", 16'd0, 16'(ain3));
    report_test("reset values", fail_cnt - err_base);

    for (int r = 0; r < ROWS; r++) begin
      if (r > 0) begin
        load_row(r);
      end
      miss_base  = miss_total;
      err_base   = fail_cnt;
      proto_base = int'(proto_err);
      @(negedge clk);
      while (!sample_valid) begin
        @(negedge clk);
      end
      check_value("ain0_o", 16'(tab_val[r][0]), 16'(ain0));
      check_value("ain1_o", 16'(tab_val[r][1]), 16'(ain1));
      check_value("ain2_o", 16'(tab_val[r][2]), 16'(ain2));
      check_value("ain3_o", 16'(tab_val[r][3]), 16'(ain3));
      check_value("missed_ack_o pulses", 16'(tab_nacks[r]), 16'(miss_total - miss_base));
      assert (int'(proto_err) == proto_base) else begin
        $display("the ADC model saw a wrong I2C sequence during row %0d", r);
        fail_cnt = fail_cnt + 1;
      end
      report_test($sformatf("row %0d", r), fail_cnt - err_base);
      @(posedge clk);
      #1;
    end

    // the last read burst still has to be closed by a STOP.
    err_base   = fail_cnt;
    proto_base = int'(proto_err);
    while (model.phase != 0) begin
      @(negedge clk);
    end
    assert (int'(proto_err) == proto_base) else begin
      $display("the ADC model saw a wrong I2C sequence at the end of the last sweep");
      fail_cnt = fail_cnt + 1;
    end
    report_test("closing stop", fail_cnt - err_base);

    $display("tests passed %0d, tests failed %0d, failed checks %0d", tests_ok, tests_bad,
             fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
